//--- hw/mm_bus_pkg.sv
/*
 * Processor bus, SRAM command and bridge FSM types.
 * The processor bus is an active-high strobe/acknowledge cycle, one cycle in flight.
 * Word addressed: bit 0 of the byte address is carried by the two byte enables.
 */
`default_nettype none

package mm_bus_pkg;

	// ----------------------------------------
	// processor side
	// ----------------------------------------
	typedef struct packed {
		logic        stb;   // cycle strobe, held until ack
		logic        rnw;   // 1 = read
		logic        uds;   // upper byte lane, bits 15:8
		logic        lds;   // lower byte lane, bits 7:0
		logic [23:1] addr;  // word address
		logic [15:0] wdata;
	} cpu_req_t;

	typedef struct packed {
		logic        ack;   // one-cycle pulse
		logic [15:0] rdata; // valid with ack only
	} cpu_rsp_t;

	// ----------------------------------------
	// bridge to sram bridge
	// ----------------------------------------
	typedef struct packed {
		logic        start; // one cycle, never while busy
		logic        rd;
		logic        hwr;   // already gated by write permission
		logic        lwr;
		logic [21:0] addr;  // sram word address
		logic [15:0] wdata;
	} ram_cmd_t;

	typedef enum logic [2:0] {
		BR_IDLE,
		BR_DECODE,
		BR_RAM,
		BR_ACK,
		BR_WAIT_LOW
	} bridge_state_t;

endpackage

`default_nettype wire

//--- hw/mm_map_pkg.sv
/*
 * Memory map of the glue logic, fixed at build time.
 * Chip and slow RAM come in 512 KB blocks; their count is set at run time by mem_cfg_t.
 * Kickstart is 512 KB of ROM held in the top SRAM bank and is never written by the processor.
 */
`default_nettype none

package mm_map_pkg;

	typedef enum logic [2:0] {
		REG_NONE,
		REG_CHIP,
		REG_SLOW,
		REG_KICK,
		REG_CIAA,
		REG_CFG
	} region_t;

	// sram bank = top 3 bits of the sram word address
	typedef enum logic [2:0] {
		CHIP0 = 3'd0, CHIP1, CHIP2, CHIP3,
		SLOW0 = 3'd4, SLOW1, SLOW2,
		KICK  = 3'd7
	} bank_t;

	typedef struct packed {
		logic [1:0] slow_size;  // 0 none .. 3 = 1.5 MB
		logic [1:0] chip_size;  // 0 = 512 KB .. 3 = 2 MB
	} mem_cfg_t;

	// ----------------------------------------
	// byte addresses
	// ----------------------------------------
	localparam logic [23:0] CHIP_BASE     = 24'h000000;
	localparam logic [23:0] SLOW_BASE     = 24'hC00000;
	localparam logic [23:0] KICK_BASE     = 24'hF80000;
	localparam logic [23:0] CIAA_PRA_ADDR = 24'hBFE001; // lower byte only
	localparam logic [23:0] CFG_MEM_ADDR  = 24'hDFF1FE;

	localparam int BLOCK_ADDR_BITS = 18;              // word bits inside 512 KB
	localparam logic [1:0] RAM_PHASES   = 2'd3;       // sram cycle length
	localparam logic [2:0] RESET_FRAMES = 3'd4;       // vsync falls before release
	localparam int LED_DIM_BITS = 4;

	localparam mem_cfg_t MEM_CFG_DEFAULT = '{slow_size: 2'd0, chip_size: 2'd0};

endpackage

`default_nettype wire

//--- hw/mm_addr_decoder.sv
/*
 * Combinational address decoder for the processor bus.
 * Address must be stable while decoded. Blocks beyond the configured memory size
 * decode as unmapped. With overlay set, reads of chip block 0 hit the kickstart ROM.
 */
`timescale 1ns/1ps
`default_nettype none

module mm_addr_decoder (
	input  wire [23:1]              addr_i,
	input  wire                     read_i,
	input  wire                     ovl_i,
	input  wire mm_map_pkg::mem_cfg_t mem_cfg_i,
	output mm_map_pkg::region_t     region_o,
	output logic [1:0]              block_o,
	output logic                    write_ok_o
);
	import mm_map_pkg::*;

	logic [1:0] blk;    // 512 KB block inside a 2 MB window

	assign blk = addr_i[BLOCK_ADDR_BITS+2:BLOCK_ADDR_BITS+1];

	always_comb begin
		region_o = REG_NONE;    // unmapped unless matched below
		if (addr_i == CIAA_PRA_ADDR[23:1]) begin
			region_o = REG_CIAA;
		end else if (addr_i == CFG_MEM_ADDR[23:1]) begin
			region_o = REG_CFG;     // sits in the slow window, so test first
		end else if (addr_i[23:21] == CHIP_BASE[23:21]) begin
			// kick shadows chip block 0 on reads while overlay is on
			if (ovl_i && read_i && blk == 2'd0)
				region_o = REG_KICK;
			else if (blk <= mem_cfg_i.chip_size)
				region_o = REG_CHIP;
		end else if (addr_i[23:21] == SLOW_BASE[23:21]) begin
			if (blk < mem_cfg_i.slow_size)  // size 0 = no slow ram
				region_o = REG_SLOW;
		end else if (addr_i[23:19] == KICK_BASE[23:19]) begin
			region_o = REG_KICK;
		end
	end

	assign block_o    = blk;
	assign write_ok_o = (region_o != REG_KICK);  // rom

endmodule

`default_nettype wire

//--- hw/mm_bank_mapper.sv
/*
 * Maps a decoded region and block onto one SRAM bank.
 * SRAM word address = {bank, low 19 word address bits}.
 * Kick accesses force bit 19 so the overlay alias at 0 and KICK_BASE hit the same word.
 */
`timescale 1ns/1ps
`default_nettype none

module mm_bank_mapper (
	input  wire mm_map_pkg::region_t region_i,
	input  wire [1:0]                block_i,
	input  wire [23:1]               addr_i,
	output logic [21:0]              ram_addr_o
);
	import mm_map_pkg::*;

	bank_t       bank;
	logic        hi_bit;    // word address bit 19
	logic [18:0] low;

	always_comb begin
		case (region_i)
			REG_CHIP: bank = bank_t'({1'b0, block_i});
			REG_SLOW: bank = bank_t'(SLOW0 + {1'b0, block_i});
			REG_KICK: bank = KICK;
			default:  bank = CHIP0;     // not a ram cycle, address unused
		endcase
	end

	// overlay reads come in with bit 19 clear
	assign hi_bit = (region_i == REG_KICK) ? KICK_BASE[BLOCK_ADDR_BITS+1]
	                                       : addr_i[BLOCK_ADDR_BITS+1];
	assign low    = {hi_bit, addr_i[BLOCK_ADDR_BITS:1]};

	assign ram_addr_o = {bank, low};

endmodule

`default_nettype wire

//--- hw/mm_cpu_bridge.sv
/*
 * Processor bus cycle FSM. Ack comes 2 cycles after strobe for registers and
 * unmapped space, 2 + RAM_PHASES for any RAM region. Strobe must drop after ack
 * before a new cycle is taken. Cycles are ignored while sys_reset is high.
 */
`timescale 1ns/1ps
`default_nettype none

module mm_cpu_bridge (
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       sys_reset_i,
	input  wire mm_bus_pkg::cpu_req_t cpu_req_i,
	input  wire mm_map_pkg::region_t  region_i,
	input  wire                       write_ok_i,
	input  wire [21:0]                ram_addr_i,
	input  wire                       ram_done_i,
	input  wire [15:0]                ram_rdata_i,
	input  wire [15:0]                reg_rdata_i,
	output mm_bus_pkg::cpu_rsp_t      cpu_rsp_o,
	output mm_bus_pkg::ram_cmd_t      ram_cmd_o,
	output logic                      reg_wr_o,
	output logic [1:0]                reg_be_o
);
	import mm_bus_pkg::*;
	import mm_map_pkg::*;

	bridge_state_t state;
	region_t       region_q;     // decode of the current cycle
	logic          write_ok_q;
	logic          ram_sel;
	logic          ack_q;
	logic [15:0]   rdata_q;
	logic [15:0]   rdata_mux;
	ram_cmd_t      cmd_q;

	assign ram_sel = region_q inside {REG_CHIP, REG_SLOW, REG_KICK};

	// ----------------------------------------
	// cycle FSM
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset || sys_reset_i) begin
			state <= BR_IDLE;
			ack_q <= 1'b0;
			cmd_q <= '0;
		end else begin
			ack_q       <= 1'b0;    // single pulse
			cmd_q.start <= 1'b0;
			case (state)
				BR_IDLE:
					if (cpu_req_i.stb) state <= BR_DECODE;
				BR_DECODE:
					if (ram_sel) begin
						cmd_q.start <= 1'b1;
						cmd_q.rd    <= cpu_req_i.rnw;
						cmd_q.hwr   <= ~cpu_req_i.rnw & cpu_req_i.uds & write_ok_q;
						cmd_q.lwr   <= ~cpu_req_i.rnw & cpu_req_i.lds & write_ok_q;
						cmd_q.addr  <= ram_addr_i;
						cmd_q.wdata <= cpu_req_i.wdata;
						state       <= BR_RAM;
					end else begin
						state <= BR_ACK;    // registers and unmapped
					end
				BR_RAM:
					if (ram_done_i) begin
						ack_q <= 1'b1;
						state <= BR_WAIT_LOW;
					end
				BR_ACK: begin
					ack_q <= 1'b1;
					state <= BR_WAIT_LOW;
				end
				BR_WAIT_LOW:
					if (!cpu_req_i.stb) state <= BR_IDLE;  // master saw ack
				default:
					state <= BR_IDLE;
			endcase
		end
	end

	// read data OR bus, sources are zero when not selected
	assign rdata_mux = cpu_req_i.rnw ? ((ram_sel ? ram_rdata_i : 16'h0000) | reg_rdata_i)
	                                 : 16'h0000;

	always_ff @(posedge clk) begin
		if (state == BR_IDLE && cpu_req_i.stb) begin
			region_q   <= region_i;
			write_ok_q <= write_ok_i;
		end
		if ((state == BR_RAM && ram_done_i) || state == BR_ACK)
			rdata_q <= rdata_mux;
	end

	assign reg_wr_o  = (state == BR_ACK) && !cpu_req_i.rnw
	                   && (region_q inside {REG_CIAA, REG_CFG});
	assign reg_be_o  = {cpu_req_i.uds, cpu_req_i.lds};
	assign ram_cmd_o = cmd_q;
	assign cpu_rsp_o = '{ack: ack_q, rdata: rdata_q};

endmodule

`default_nettype wire

//--- hw/mm_sram_bridge.sv
/*
 * Three-phase asynchronous SRAM access, all pins active low and registered.
 * Phase 1 address and lanes, phase 2 OE or WE, phase 3 capture and release.
 * A new start is only accepted while idle.
 */
`timescale 1ns/1ps
`default_nettype none

module mm_sram_bridge (
	input  wire                       clk,
	input  wire                       reset,
	input  wire mm_bus_pkg::ram_cmd_t ram_cmd_i,
	input  wire [15:0]                ram_data_i,
	output logic                      ram_done_o,
	output logic [15:0]               ram_rdata_o,
	output logic [21:0]               ram_addr_o,
	output logic [15:0]               ram_data_o,
	output logic                      ram_oe_n_o,
	output logic                      ram_we_n_o,
	output logic                      ram_bhe_n_o,
	output logic                      ram_ble_n_o
);
	import mm_bus_pkg::*;
	import mm_map_pkg::*;

	logic [1:0] ph;     // 0 idle, then 1..RAM_PHASES
	logic       rd_q;
	logic       wr_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			ph          <= 2'd0;
			ram_oe_n_o  <= 1'b1;
			ram_we_n_o  <= 1'b1;
			ram_bhe_n_o <= 1'b1;
			ram_ble_n_o <= 1'b1;
		end else begin
			case (ph)
				2'd0:
					if (ram_cmd_i.start) begin
						ph          <= 2'd1;
						ram_bhe_n_o <= ~(ram_cmd_i.rd | ram_cmd_i.hwr);  // reads take both
						ram_ble_n_o <= ~(ram_cmd_i.rd | ram_cmd_i.lwr);
					end
				2'd1: begin
					ph         <= 2'd2;
					ram_oe_n_o <= ~rd_q;
					ram_we_n_o <= ~wr_q;    // low for phase 2 only
				end
				2'd2: begin
					ph          <= RAM_PHASES;
					ram_oe_n_o  <= 1'b1;
					ram_we_n_o  <= 1'b1;
					ram_bhe_n_o <= 1'b1;
					ram_ble_n_o <= 1'b1;
				end
				default: ph <= 2'd0;
			endcase
		end
	end

	// payload, held until the next start
	always_ff @(posedge clk) begin
		if (ph == 2'd0 && ram_cmd_i.start) begin
			ram_addr_o <= ram_cmd_i.addr;
			ram_data_o <= ram_cmd_i.wdata;
			rd_q       <= ram_cmd_i.rd;
			wr_q       <= ram_cmd_i.hwr | ram_cmd_i.lwr;
		end
		if (ph == 2'd2 && rd_q)
			ram_rdata_o <= ram_data_i;  // end of oe window
	end

	assign ram_done_o = (ph == RAM_PHASES);

endmodule

`default_nettype wire

//--- hw/mm_ctrl_regs.sv
/*
 * CIA-A port A register (overlay, LED) and memory config register.
 * Read data is zero unless the current address selects a register.
 * Port writes need the lower byte lane, as do config writes.
 */
`timescale 1ns/1ps
`default_nettype none

module mm_ctrl_regs (
	input  wire                      clk,
	input  wire                      sys_reset_i,
	input  wire mm_map_pkg::region_t region_i,
	input  wire                      reg_wr_i,
	input  wire [1:0]                reg_be_i,
	input  wire [15:0]               wdata_i,
	input  wire                      hsync_i,
	output logic [15:0]              reg_rdata_o,
	output logic                     ovl_o,
	output mm_map_pkg::mem_cfg_t     mem_cfg_o,
	output logic                     pwrled_o
);
	import mm_map_pkg::*;

	logic                    ovl_q;      // pra bit 0
	logic                    led_q;      // pra bit 1, 1 = led off
	mem_cfg_t                cfg_q;
	logic                    sel_pra;
	logic                    sel_cfg;
	logic [LED_DIM_BITS-1:0] dim_cnt;

	assign sel_pra = (region_i == REG_CIAA);
	assign sel_cfg = (region_i == REG_CFG);

	always_ff @(posedge clk) begin
		if (sys_reset_i) begin
			ovl_q <= 1'b1;      // boot from rom
			led_q <= 1'b0;
			cfg_q <= MEM_CFG_DEFAULT;
		end else if (reg_wr_i && reg_be_i[0]) begin
			if (sel_pra)
				{led_q, ovl_q} <= wdata_i[1:0];
			if (sel_cfg)
				cfg_q <= wdata_i[3:0];
		end
	end

	always_comb begin
		reg_rdata_o = 16'h0000;
		if (sel_pra)
			reg_rdata_o = {14'h0000, led_q, ovl_q};
		else if (sel_cfg)
			reg_rdata_o = {12'h000, cfg_q};
	end

	// ----------------------------------------
	// power led dimmer
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (sys_reset_i)
			dim_cnt <= '0;
		else if (hsync_i)
			dim_cnt <= dim_cnt + 1'b1;
	end

	// "off" is a dim glow, one count in 2**LED_DIM_BITS
	assign pwrled_o  = led_q ? (dim_cnt == '0) : 1'b1;
	assign ovl_o     = ovl_q;
	assign mem_cfg_o = cfg_q;

endmodule

`default_nettype wire

//--- hw/mm_sys_control.sv
/*
 * System reset sequencer. reset or rst_ext_i starts a hold that lasts
 * RESET_FRAMES falling edges of vsync_i; outputs drop the cycle after the last.
 * rst_ext_i during the hold restarts the count.
 */
`timescale 1ns/1ps
`default_nettype none

module mm_sys_control (
	input  wire  clk,
	input  wire  reset,
	input  wire  rst_ext_i,
	input  wire  vsync_i,
	output logic sys_reset_o,
	output logic cpu_reset_o
);
	import mm_map_pkg::*;

	logic       vs_q;       // vsync one cycle back
	logic       vs_fall;
	logic       hold;
	logic [2:0] frames;     // falls seen so far

	assign vs_fall = vs_q & ~vsync_i;

	always_ff @(posedge clk) begin
		if (reset || rst_ext_i) begin
			vs_q   <= 1'b0;     // no false edge out of reset
			hold   <= 1'b1;
			frames <= 3'd0;
		end else begin
			vs_q <= vsync_i;
			if (hold && vs_fall) begin
				frames <= frames + 3'd1;
				if (frames == RESET_FRAMES - 3'd1)
					hold <= 1'b0;   // last frame
			end
		end
	end

	assign sys_reset_o = hold;
	assign cpu_reset_o = hold;

endmodule

`default_nettype wire

//--- hw/mm_glue_top.sv
/*
 * Glue top: processor bus bridge, decoder, bank mapper, SRAM bridge,
 * control registers and reset sequencer. One external 16-bit SRAM of 4M words.
 */
`timescale 1ns/1ps
`default_nettype none

module mm_glue_top (
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       rst_ext_i,
	input  wire                       vsync_i,
	input  wire                       hsync_i,
	input  wire mm_bus_pkg::cpu_req_t cpu_req_i,
	input  wire [15:0]                ram_data_i,
	output mm_bus_pkg::cpu_rsp_t      cpu_rsp_o,
	output logic                      cpu_reset_o,
	output logic [21:0]               ram_addr_o,
	output logic [15:0]               ram_data_o,
	output logic                      ram_oe_n_o,
	output logic                      ram_we_n_o,
	output logic                      ram_bhe_n_o,
	output logic                      ram_ble_n_o,
	output logic                      pwrled_o
);
	import mm_bus_pkg::*;
	import mm_map_pkg::*;

	// ----------------------------------------
	// internal buses
	// ----------------------------------------
	region_t     region;
	logic [1:0]  block;
	logic        write_ok;
	logic [21:0] map_addr;     // sram address from the mapper
	ram_cmd_t    ram_cmd;
	logic        ram_done;
	logic [15:0] ram_rdata;
	logic [15:0] reg_rdata;
	logic        reg_wr;
	logic [1:0]  reg_be;
	logic        ovl;
	mem_cfg_t    mem_cfg;
	logic        sys_reset;

	mm_addr_decoder i_decoder (
		.addr_i    (cpu_req_i.addr),
		.read_i    (cpu_req_i.rnw),
		.ovl_i     (ovl),
		.mem_cfg_i (mem_cfg),
		.region_o  (region),
		.block_o   (block),
		.write_ok_o(write_ok)
	);

	mm_bank_mapper i_mapper (
		.region_i  (region),
		.block_i   (block),
		.addr_i    (cpu_req_i.addr),
		.ram_addr_o(map_addr)
	);

	mm_cpu_bridge i_bridge (
		.clk        (clk),
		.reset      (reset),
		.sys_reset_i(sys_reset),
		.cpu_req_i  (cpu_req_i),
		.region_i   (region),
		.write_ok_i (write_ok),
		.ram_addr_i (map_addr),
		.ram_done_i (ram_done),
		.ram_rdata_i(ram_rdata),
		.reg_rdata_i(reg_rdata),
		.cpu_rsp_o  (cpu_rsp_o),
		.ram_cmd_o  (ram_cmd),
		.reg_wr_o   (reg_wr),
		.reg_be_o   (reg_be)
	);

	mm_sram_bridge i_sram (
		.clk        (clk),
		.reset      (reset),
		.ram_cmd_i  (ram_cmd),
		.ram_data_i (ram_data_i),
		.ram_done_o (ram_done),
		.ram_rdata_o(ram_rdata),
		.ram_addr_o (ram_addr_o),
		.ram_data_o (ram_data_o),
		.ram_oe_n_o (ram_oe_n_o),
		.ram_we_n_o (ram_we_n_o),
		.ram_bhe_n_o(ram_bhe_n_o),
		.ram_ble_n_o(ram_ble_n_o)
	);

	mm_ctrl_regs i_regs (
		.clk        (clk),
		.sys_reset_i(sys_reset),
		.region_i   (region),
		.reg_wr_i   (reg_wr),
		.reg_be_i   (reg_be),
		.wdata_i    (cpu_req_i.wdata),
		.hsync_i    (hsync_i),
		.reg_rdata_o(reg_rdata),
		.ovl_o      (ovl),
		.mem_cfg_o  (mem_cfg),
		.pwrled_o   (pwrled_o)
	);

	mm_sys_control i_sysctl (
		.clk        (clk),
		.reset      (reset),
		.rst_ext_i  (rst_ext_i),
		.vsync_i    (vsync_i),
		.sys_reset_o(sys_reset),
		.cpu_reset_o(cpu_reset_o)
	);

endmodule

`default_nettype wire

//--- verif/tb_glue_top.sv
/*
 * Testbench for the glue top. SRAM is modelled as 4M words, kick bank preloaded
 * from an LFSR, the rest with an address pattern. Bus latency is counted from
 * the first edge that sees strobe. Needs a simulator with timing and assertions on.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_glue_top;
	import mm_bus_pkg::*;
	import mm_map_pkg::*;

	localparam int SRAM_WORDS  = 1 << 22;
	localparam int BUS_TIMEOUT = 40;                 // cycles
	localparam int REG_LAT     = 2;                  // registers and unmapped
	localparam int RAM_LAT     = 2 + int'(RAM_PHASES);
	localparam int LED_WINDOW  = 64;

	logic        clk = 1'b0;
	logic        reset = 1'b1;
	logic        rst_ext_i = 1'b0;
	logic        vsync_i = 1'b0;
	logic        hsync_i = 1'b0;
	cpu_req_t    cpu_req = '0;
	cpu_rsp_t    cpu_rsp;
	logic        cpu_reset;
	logic [21:0] ram_addr;
	logic [15:0] ram_wdata;
	logic [15:0] ram_rdata;
	logic        ram_oe_n;
	logic        ram_we_n;
	logic        ram_bhe_n;
	logic        ram_ble_n;
	logic        pwrled;
	logic [15:0] sram [SRAM_WORDS];
	int          errors = 0;
	int          checks = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	logic        mon_on = 1'b0;     // address watch enable
	logic [21:0] mon_addr = '0;
	int          mon_hits = 0;
	int          mon_errors = 0;

	always #20 clk = ~clk;

	mm_glue_top i_dut (
		.clk(clk), .reset(reset), .rst_ext_i(rst_ext_i), .vsync_i(vsync_i),
		.hsync_i(hsync_i), .cpu_req_i(cpu_req), .ram_data_i(ram_rdata),
		.cpu_rsp_o(cpu_rsp), .cpu_reset_o(cpu_reset), .ram_addr_o(ram_addr),
		.ram_data_o(ram_wdata), .ram_oe_n_o(ram_oe_n), .ram_we_n_o(ram_we_n),
		.ram_bhe_n_o(ram_bhe_n), .ram_ble_n_o(ram_ble_n), .pwrled_o(pwrled)
	);

	// ----------------------------------------
	// sram model
	// ----------------------------------------
	assign ram_rdata = ram_oe_n ? 16'h0000 : sram[ram_addr];

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
	endfunction

	initial begin : sram_model
		logic [31:0] lfsr;
		logic [15:0] w;
		logic [21:0] a;
		lfsr = 32'd32;
		w = '0;
		for (int i = 0; i < SRAM_WORDS; i++) begin
			a = i[21:0];
			if (a[21:19] == KICK) begin
				for (int b = 0; b < 16; b++) begin
					lfsr = lfsr_next(lfsr);
					w = {w[14:0], lfsr[0]};     // one step per bit
				end
				sram[a] = w;
			end else begin
				sram[a] = a[15:0] ^ {10'h000, a[21:16]};
			end
		end
		forever begin
			@(negedge clk);
			if (!ram_we_n) begin
				if (!ram_bhe_n) sram[ram_addr][15:8] = ram_wdata[15:8];
				if (!ram_ble_n) sram[ram_addr][7:0] = ram_wdata[7:0];
			end
		end
	end

	// pin monitor, kick never written, address watch
	always @(negedge clk) begin
		assert (ram_we_n || ram_addr[21:19] != KICK) else begin
			$display("%0t: write strobe reached the kick bank at 0x%06h", $time, ram_addr);
			mon_errors++;
		end
		if (mon_on && !(ram_oe_n && ram_we_n && ram_bhe_n && ram_ble_n)) begin
			mon_hits++;
			assert (ram_addr == mon_addr) else begin
				$display("** Error at %0t: ram_addr_o = 0x%06h, expected 0x%06h",
				         $time, ram_addr, mon_addr);
				mon_errors++;
			end
		end
	end

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	function automatic int total_errors();
		return errors + mon_errors;
	endfunction

	function automatic logic [21:0] ram_word(input bank_t bank, input logic [23:0] a);
		return {bank, a[19:1]};
	endfunction

	// overlay and KICK_BASE alias onto the same word
	function automatic logic [21:0] kick_word(input logic [23:0] a);
		return {KICK, KICK_BASE[19], a[18:1]};
	endfunction

	function automatic logic [15:0] merge_lanes(input logic [15:0] old, input logic [15:0] nw,
	                                           input logic [1:0] be);
		return {be[1] ? nw[15:8] : old[15:8], be[0] ? nw[7:0] : old[7:0]};
	endfunction

	task automatic expect16(input string sig, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("** Error at %0t: %s = 0x%04h, expected 0x%04h", $time, sig, got, exp);
			errors++;
		end
	endtask

	task automatic expect_int(input string sig, input int got, input int exp);
		checks++;
		assert (got == exp) else begin
			$display("** Error at %0t: %s = %0d, expected %0d", $time, sig, got, exp);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int errs_before);
		int n;
		n = total_errors() - errs_before;
		tests_run++;
		if (n == 0) begin
			$display("test %0d %s: pass", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, n);
		end
	endtask

	// one bus cycle, late = cycles strobe stays up after ack
	task automatic bus_cycle(input logic rnw, input logic [1:0] be, input logic [23:0] byte_addr,
	                         input logic [15:0] wdata, input int late,
	                         output logic [15:0] rdata, output int lat);
		int   n;
		logic seen;
		n = 0;
		seen = 1'b0;
		rdata = '0;
		lat = -1;
		@(posedge clk);
		cpu_req <= '{stb: 1'b1, rnw: rnw, uds: be[1], lds: be[0],
		             addr: byte_addr[23:1], wdata: wdata};
		while (!seen && n < BUS_TIMEOUT) begin
			@(negedge clk);
			n++;
			if (cpu_rsp.ack) begin
				seen = 1'b1;
				rdata = cpu_rsp.rdata;
				lat = n - 2;    // first sampling edge is cycle 0
			end
		end
		if (!seen) begin
			$display("%0t: no acknowledge within %0d cycles at address 0x%06h",
			         $time, BUS_TIMEOUT, byte_addr);
			errors++;
		end
		for (int i = 0; i < late; i++) begin
			@(negedge clk);
			expect_int("cpu_rsp_o.ack with strobe held", int'(cpu_rsp.ack), 0);
		end
		@(posedge clk);
		cpu_req.stb <= 1'b0;
	endtask

	task automatic read_check(input logic [23:0] a, input logic [1:0] be,
	                          input logic [15:0] exp, input int exp_lat);
		logic [15:0] d;
		int          lat;
		bus_cycle(1'b1, be, a, 16'h0000, 0, d, lat);
		expect16($sformatf("cpu_rsp_o.rdata[0x%06h]", a), d, exp);
		expect_int($sformatf("read ack cycle[0x%06h]", a), lat, exp_lat);
	endtask

	task automatic write_check(input logic [23:0] a, input logic [1:0] be,
	                           input logic [15:0] data, input int exp_lat);
		logic [15:0] d;
		int          lat;
		bus_cycle(1'b0, be, a, data, 0, d, lat);
		expect_int($sformatf("write ack cycle[0x%06h]", a), lat, exp_lat);
	endtask

	task automatic vsync_pulse();
		@(posedge clk);
		vsync_i <= 1'b1;
		repeat (3) @(posedge clk);
		vsync_i <= 1'b0;            // the falling edge counts
	endtask

	task automatic ext_reset_pulse();
		@(posedge clk);
		rst_ext_i <= 1'b1;
		@(posedge clk);
		rst_ext_i <= 1'b0;
		@(negedge clk);
		expect_int("cpu_reset_o after rst_ext_i", int'(cpu_reset), 1);
	endtask

	task automatic ignored_strobe(input logic [23:0] a);
		@(posedge clk);
		cpu_req <= '{stb: 1'b1, rnw: 1'b1, uds: 1'b1, lds: 1'b1, addr: a[23:1], wdata: '0};
		repeat (8) begin
			@(negedge clk);
			expect_int("cpu_rsp_o.ack during reset", int'(cpu_rsp.ack), 0);
		end
		@(posedge clk);
		cpu_req.stb <= 1'b0;
	endtask

	// full count of frames, reset must drop one cycle after the last fall
	task automatic release_sequence();
		int n;
		for (int f = 1; f <= int'(RESET_FRAMES); f++) begin
			vsync_pulse();
			if (f < int'(RESET_FRAMES)) begin
				repeat (3) @(negedge clk);
				expect_int($sformatf("cpu_reset_o after frame %0d", f), int'(cpu_reset), 1);
			end
		end
		n = 0;
		while (cpu_reset && n < 10) begin
			@(negedge clk);
			n++;
		end
		if (cpu_reset) begin
			$display("%0t: cpu_reset_o did not fall after the last frame", $time);
			errors++;
		end else begin
			expect_int("cpu_reset_o fall cycle", n, 2);
		end
	endtask

	task automatic count_led_high(output int high);
		high = 0;
		repeat (LED_WINDOW) begin
			@(negedge clk);
			if (pwrled) high++;
		end
	endtask

	// ----------------------------------------
	// tests
	// ----------------------------------------
	task automatic test_reset();
		int e0;
		e0 = total_errors();
		@(negedge clk);
		expect_int("cpu_reset_o", int'(cpu_reset), 1);
		expect_int("cpu_rsp_o.ack", int'(cpu_rsp.ack), 0);
		expect_int("ram oe/we/bhe/ble", int'({ram_oe_n, ram_we_n, ram_bhe_n, ram_ble_n}), 15);
		expect_int("pwrled_o", int'(pwrled), 1);
		ignored_strobe(24'h000000);
		release_sequence();
		ext_reset_pulse();
		vsync_pulse();
		vsync_pulse();
		ext_reset_pulse();          // count starts over
		release_sequence();
		end_test("reset sequencing", e0);
	endtask

	task automatic test_timing();
		int          e0;
		int          lat;
		logic [15:0] d;
		e0 = total_errors();
		read_check(CFG_MEM_ADDR, 2'b11, {12'h000, MEM_CFG_DEFAULT}, REG_LAT);
		read_check(24'h000400, 2'b11, sram[kick_word(24'h000400)], RAM_LAT);  // overlay on
		read_check(24'h400000, 2'b11, 16'h0000, REG_LAT);
		bus_cycle(1'b1, 2'b11, CFG_MEM_ADDR, 16'h0000, 6, d, lat);     // slow master
		expect_int("slow master ack cycle", lat, REG_LAT);
		read_check(24'h000400, 2'b11, sram[kick_word(24'h000400)], RAM_LAT);
		end_test("ack timing", e0);
	endtask

	task automatic test_overlay();
		int          e0;
		logic [15:0] kick_w;
		e0 = total_errors();
		kick_w = sram[kick_word(24'h000000)];
		read_check(24'h000000, 2'b11, kick_w, RAM_LAT);
		write_check(24'h000000, 2'b11, 16'h1234, RAM_LAT);
		expect16("sram chip word 0", sram[ram_word(CHIP0, 24'h000000)], 16'h1234);
		read_check(24'h000000, 2'b11, kick_w, RAM_LAT);      // still shadowed
		write_check(CIAA_PRA_ADDR, 2'b01, 16'h0000, REG_LAT);
		read_check(24'h000000, 2'b11, 16'h1234, RAM_LAT);
		write_check(KICK_BASE, 2'b11, 16'hBEEF, RAM_LAT);    // refused
		read_check(KICK_BASE, 2'b11, kick_w, RAM_LAT);
		expect16("sram kick word 0", sram[kick_word(KICK_BASE)], kick_w);
		end_test("overlay", e0);
	endtask

	task automatic test_lanes();
		int          e0;
		int          h0;
		logic [23:0] a;
		logic [15:0] shadow;
		e0 = total_errors();
		h0 = mon_hits;
		a = 24'h000100;
		mon_addr = ram_word(CHIP0, a);
		mon_on = 1'b1;
		shadow = 16'hAAAA;
		write_check(a, 2'b11, shadow, RAM_LAT);
		read_check(a, 2'b11, shadow, RAM_LAT);
		write_check(a, 2'b10, 16'h1299, RAM_LAT);   // upper only
		shadow = merge_lanes(shadow, 16'h1299, 2'b10);
		read_check(a, 2'b11, shadow, RAM_LAT);
		write_check(a, 2'b01, 16'h5634, RAM_LAT);   // lower only
		shadow = merge_lanes(shadow, 16'h5634, 2'b01);
		read_check(a, 2'b11, shadow, RAM_LAT);
		expect16("sram chip word 0x80", sram[mon_addr], shadow);
		mon_on = 1'b0;
		expect_int("sram strobe cycles watched", int'(mon_hits > h0), 1);
		end_test("byte lanes and mapping", e0);
	endtask

	task automatic test_memcfg();
		int          e0;
		logic [23:0] blk1;
		logic [15:0] snap;
		e0 = total_errors();
		blk1 = 24'h080000;
		read_check(blk1, 2'b11, 16'h0000, REG_LAT);
		snap = sram[ram_word(CHIP1, blk1)];
		write_check(blk1, 2'b11, 16'h5555, REG_LAT);
		expect16("sram chip block 1", sram[ram_word(CHIP1, blk1)], snap);
		read_check(SLOW_BASE, 2'b11, 16'h0000, REG_LAT);
		snap = sram[ram_word(SLOW0, SLOW_BASE)];
		write_check(SLOW_BASE, 2'b11, 16'h5555, REG_LAT);
		expect16("sram slow block 0", sram[ram_word(SLOW0, SLOW_BASE)], snap);
		// chip size 1, slow size 1
		write_check(CFG_MEM_ADDR, 2'b11, 16'h0005, REG_LAT);
		read_check(CFG_MEM_ADDR, 2'b11, 16'h0005, REG_LAT);
		mon_addr = ram_word(CHIP1, blk1);
		mon_on = 1'b1;
		write_check(blk1, 2'b11, 16'h5A5A, RAM_LAT);
		read_check(blk1, 2'b11, 16'h5A5A, RAM_LAT);
		expect16("sram chip block 1", sram[mon_addr], 16'h5A5A);
		mon_addr = ram_word(SLOW0, SLOW_BASE);
		write_check(SLOW_BASE, 2'b11, 16'hC3C3, RAM_LAT);
		read_check(SLOW_BASE, 2'b11, 16'hC3C3, RAM_LAT);
		expect16("sram slow block 0", sram[mon_addr], 16'hC3C3);
		mon_on = 1'b0;
		end_test("memory config", e0);
	endtask

	task automatic test_led();
		int e0;
		int high;
		e0 = total_errors();
		write_check(CIAA_PRA_ADDR, 2'b01, 16'h0000, REG_LAT);
		read_check(CIAA_PRA_ADDR, 2'b01, 16'h0000, REG_LAT);
		@(posedge clk);
		hsync_i <= 1'b1;
		count_led_high(high);
		expect_int("pwrled_o high cycles, led on", high, LED_WINDOW);
		write_check(CIAA_PRA_ADDR, 2'b01, 16'h0003, REG_LAT);   // overlay and led off bits
		read_check(CIAA_PRA_ADDR, 2'b01, 16'h0003, REG_LAT);
		count_led_high(high);
		expect_int("pwrled_o high cycles, dimmed", high, LED_WINDOW >> LED_DIM_BITS);
		end_test("port register and led", e0);
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		test_reset();
		test_timing();
		test_overlay();
		test_lanes();
		test_memcfg();
		test_led();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
		         tests_run, tests_failed, checks, total_errors());
		if (tests_failed == 0 && total_errors() == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
hw/mm_bus_pkg.sv
hw/mm_map_pkg.sv
hw/mm_addr_decoder.sv
hw/mm_bank_mapper.sv
hw/mm_cpu_bridge.sv
hw/mm_sram_bridge.sv
hw/mm_ctrl_regs.sv
hw/mm_sys_control.sv
hw/mm_glue_top.sv
verif/tb_glue_top.sv

//--- Makefile
# Verilator build for the glue top testbench

VERILATOR ?= verilator
FLAGS     := --timing --assert
TOP       := tb_glue_top
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@grep -q "Test OK" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
